/* all.f */
hw/rv32i_pkg.sv
hw/control_rom.sv
hw/regfile.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/rv32i_core_top.sv
test/tb_checker.sv
test/tb_top.sv

/* hw/control_rom.sv */
`timescale 1ns/1ns
`default_nettype none

module control_rom
    import rv32i_pkg::*;
(
    input  opcode_e    opcode_i,
    input  logic [2:0] funct3_i,
    input  logic [6:0] funct7_i,
    output ctrl_word_t ctrl_o
);

    ctrl_word_t ctrl;
    logic       bad;
    // funct7 may only be all zero or carry the sub/sra bit
    logic       f7_zero;
    logic       f7_alt;

    assign f7_zero = (funct7_i == 7'b0000000);
    assign f7_alt  = (funct7_i == 7'b0100000);

    always_comb begin : rom
        ctrl = NOP_CTRL;
        bad  = 1'b0;
        ctrl.opcode = opcode_i;

        unique case (funct3_i)
            3'b000:  ctrl.alu_op = alu_add;
            3'b001:  ctrl.alu_op = alu_sll;
            3'b010:  ctrl.alu_op = alu_slt;
            3'b011:  ctrl.alu_op = alu_sltu;
            3'b100:  ctrl.alu_op = alu_xor;
            3'b101:  ctrl.alu_op = f7_alt ? alu_sra : alu_srl;
            3'b110:  ctrl.alu_op = alu_or;
            default: ctrl.alu_op = alu_and;
        endcase

        case (opcode_i)
            op_lui, op_auipc: begin
                ctrl.alu_op       = alu_add;
                ctrl.alumux1_sel  = (opcode_i == op_auipc) ? alu_a_pc : alu_a_rs1;
                ctrl.alumux2_sel  = alu_b_imm;
                ctrl.load_regfile = 1'b1;
            end
            op_br: begin
                // target is pc + b_imm
                ctrl.alu_op      = alu_add;
                ctrl.alumux1_sel = alu_a_pc;
                ctrl.alumux2_sel = alu_b_imm;
                ctrl.cmpop       = branch_funct3_e'(funct3_i);
                bad = (funct3_i == 3'b010) || (funct3_i == 3'b011);
            end
            op_imm: begin
                ctrl.alumux2_sel  = alu_b_imm;
                ctrl.load_regfile = 1'b1;
                // only shifts look at funct7 for immediates
                if (funct3_i == 3'b001)
                    bad = !f7_zero;
                else if (funct3_i == 3'b101)
                    bad = !(f7_zero || f7_alt);
            end
            op_reg: begin
                ctrl.alumux2_sel  = alu_b_rs2;
                ctrl.load_regfile = 1'b1;
                if (funct3_i == 3'b000) begin
                    ctrl.alu_op = f7_alt ? alu_sub : alu_add;
                    bad = !(f7_zero || f7_alt);
                end else if (funct3_i == 3'b101) begin
                    bad = !(f7_zero || f7_alt);
                end else begin
                    bad = !f7_zero;
                end
            end
            default: bad = 1'b1;
        endcase

        if (bad) begin
            ctrl = NOP_CTRL;
            ctrl.illegal = 1'b1;
        end
    end

    assign ctrl_o = ctrl;

endmodule : control_rom

`default_nettype wire

/* hw/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage
    import rv32i_pkg::*;
#(
    parameter int REG_COUNT = 32
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        in_valid_i,
    output logic        in_ready_o,
    input  logic [31:0] in_pc_i,
    input  logic [31:0] in_instr_i,
    input  logic        stall_i,
    input  logic [4:0]  ex_rd_i,
    input  logic        ex_we_i,
    input  logic        ex_valid_i,
    input  logic [4:0]  res_rd_i,
    input  logic        res_we_i,
    input  logic        res_valid_i,
    input  logic        res_accept_i,
    input  logic        wb_we_i,
    input  logic [4:0]  wb_rd_i,
    input  logic [31:0] wb_data_i,
    output id_ex_t      id_ex_o,
    output logic        id_valid_o
);

    opcode_e     opcode;
    logic [4:0]  rs1, rs2, rd;
    logic [31:0] i_imm, s_imm, b_imm, u_imm, j_imm;
    logic [31:0] rs1_val, rs2_val;
    ctrl_word_t  rom_ctrl, ctrl;
    logic        uses_rs1, uses_rs2, bad_idx, cmp_true;
    logic        reads1, reads2, hazard, accept;
    logic        id_we;
    id_ex_t      id_ex_d, id_ex_q;
    logic        id_valid_q;

    assign opcode = opcode_e'(in_instr_i[6:0]);
    assign rs1    = in_instr_i[19:15];
    assign rs2    = in_instr_i[24:20];
    assign rd     = in_instr_i[11:7];

    assign i_imm = {{21{in_instr_i[31]}}, in_instr_i[30:20]};
    assign s_imm = {{21{in_instr_i[31]}}, in_instr_i[30:25], in_instr_i[11:7]};
    assign b_imm = {{20{in_instr_i[31]}}, in_instr_i[7], in_instr_i[30:25],
                    in_instr_i[11:8], 1'b0};
    assign u_imm = {in_instr_i[31:12], 12'h000};
    assign j_imm = {{12{in_instr_i[31]}}, in_instr_i[19:12], in_instr_i[20],
                    in_instr_i[30:21], 1'b0};

    control_rom ctrl_rom (
        .opcode_i (opcode),
        .funct3_i (in_instr_i[14:12]),
        .funct7_i (in_instr_i[31:25]),
        .ctrl_o   (rom_ctrl)
    );

    regfile #(.REG_COUNT(REG_COUNT)) rf (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .we_i       (wb_we_i),
        .rd_i       (wb_rd_i),
        .wdata_i    (wb_data_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rs1_data_o (rs1_val),
        .rs2_data_o (rs2_val)
    );

    // which source registers the instruction really reads
    assign uses_rs1 = !rom_ctrl.illegal &&
                      (opcode == op_reg || opcode == op_imm || opcode == op_br);
    assign uses_rs2 = !rom_ctrl.illegal && (opcode == op_reg || opcode == op_br);

    // RV32E style indices beyond the file
    assign bad_idx = (uses_rs1 && int'(rs1) >= REG_COUNT) ||
                     (uses_rs2 && int'(rs2) >= REG_COUNT) ||
                     (rom_ctrl.load_regfile && int'(rd) >= REG_COUNT);

    always_comb begin : fix_ctrl
        ctrl = rom_ctrl;
        if (bad_idx) begin
            ctrl = NOP_CTRL;
            ctrl.illegal = 1'b1;
        end
    end

    always_comb begin : branch_cmp
        case (ctrl.cmpop)
            beq:     cmp_true = (rs1_val == rs2_val);
            bne:     cmp_true = (rs1_val != rs2_val);
            blt:     cmp_true = ($signed(rs1_val) < $signed(rs2_val));
            bge:     cmp_true = ($signed(rs1_val) >= $signed(rs2_val));
            bltu:    cmp_true = (rs1_val < rs2_val);
            default: cmp_true = (rs1_val >= rs2_val);
        endcase
    end

    always_comb begin : build_id_ex
        id_ex_d.pc      = in_pc_i;
        id_ex_d.ctrl    = ctrl;
        id_ex_d.rs1_val = rs1_val;
        id_ex_d.rs2_val = rs2_val;
        id_ex_d.rd      = rd;
        id_ex_d.br_taken = (ctrl.opcode == op_br) && !ctrl.illegal && cmp_true;
        case (opcode)
            op_lui, op_auipc: id_ex_d.imm = u_imm;
            op_br:            id_ex_d.imm = b_imm;
            op_store:         id_ex_d.imm = s_imm;
            op_jal:           id_ex_d.imm = j_imm;
            default:          id_ex_d.imm = i_imm;
        endcase
        // bubble when nothing is accepted
        if (!accept) begin
            id_ex_d.ctrl     = NOP_CTRL;
            id_ex_d.br_taken = 1'b0;
        end
    end

    // hazard against the three older slots
    assign reads1 = uses_rs1 && !ctrl.illegal && (rs1 != 5'd0);
    assign reads2 = uses_rs2 && !ctrl.illegal && (rs2 != 5'd0);
    assign id_we  = id_valid_q && id_ex_q.ctrl.load_regfile && !id_ex_q.ctrl.illegal &&
                    (id_ex_q.rd != 5'd0);

    assign hazard =
        (id_we && ((reads1 && id_ex_q.rd == rs1) || (reads2 && id_ex_q.rd == rs2))) ||
        (ex_valid_i && ex_we_i && ((reads1 && ex_rd_i == rs1) || (reads2 && ex_rd_i == rs2))) ||
        (res_valid_i && res_we_i && !res_accept_i &&
         ((reads1 && res_rd_i == rs1) || (reads2 && res_rd_i == rs2)));

    assign in_ready_o = !stall_i && !hazard;
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_valid_q <= 1'b0;
        end else if (!stall_i) begin
            id_valid_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i)
            id_ex_q <= id_ex_d;
    end

    assign id_ex_o    = id_ex_q;
    assign id_valid_o = id_valid_q;

endmodule : decode_stage

`default_nettype wire

/* hw/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage
    import rv32i_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  id_ex_t     id_ex_i,
    input  logic       id_valid_i,
    output logic       stall_o,
    input  logic       res_full_i,
    input  logic       res_accept_i,
    output ex_res_t    ex_res_o,
    output logic       ex_valid_o,
    output logic [4:0] ex_rd_o,
    output logic       ex_we_o
);

    logic [31:0] op_a, op_b, alu_out;
    logic [4:0]  shamt;
    ex_res_t     ex_res_d, ex_res_q;
    logic        ex_valid_q;

    // lui adds its immediate to zero
    always_comb begin : operand_mux
        if (id_ex_i.ctrl.opcode == op_lui)
            op_a = '0;
        else if (id_ex_i.ctrl.alumux1_sel == alu_a_pc)
            op_a = id_ex_i.pc;
        else
            op_a = id_ex_i.rs1_val;
        op_b = (id_ex_i.ctrl.alumux2_sel == alu_b_imm) ? id_ex_i.imm : id_ex_i.rs2_val;
    end

    assign shamt = op_b[4:0];

    always_comb begin : alu
        case (id_ex_i.ctrl.alu_op)
            alu_add:  alu_out = op_a + op_b;
            alu_sub:  alu_out = op_a - op_b;
            alu_sll:  alu_out = op_a << shamt;
            alu_slt:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_out = {31'b0, op_a < op_b};
            alu_xor:  alu_out = op_a ^ op_b;
            alu_srl:  alu_out = op_a >> shamt;
            alu_sra:  alu_out = $unsigned($signed(op_a) >>> shamt);
            alu_or:   alu_out = op_a | op_b;
            default:  alu_out = op_a & op_b;
        endcase
    end

    always_comb begin : build_record
        ex_res_d.pc       = id_ex_i.pc;
        ex_res_d.rd       = id_ex_i.rd;
        ex_res_d.value    = id_ex_i.ctrl.illegal ? 32'd0 : alu_out;
        ex_res_d.we       = id_ex_i.ctrl.load_regfile && !id_ex_i.ctrl.illegal &&
                            (id_ex_i.rd != 5'd0);
        ex_res_d.br_taken = id_ex_i.br_taken;
        ex_res_d.illegal  = id_ex_i.ctrl.illegal;
    end

    // hold while the result register is full and not draining
    assign stall_o = ex_valid_q && res_full_i && !res_accept_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_valid_q <= 1'b0;
        end else if (!stall_o) begin
            ex_valid_q <= id_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_o)
            ex_res_q <= ex_res_d;
    end

    assign ex_res_o   = ex_res_q;
    assign ex_valid_o = ex_valid_q;
    assign ex_rd_o    = ex_res_q.rd;
    assign ex_we_o    = ex_res_q.we;

endmodule : execute_stage

`default_nettype wire

/* hw/regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module regfile #(
    parameter int REG_COUNT = 32
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        we_i,
    input  logic [4:0]  rd_i,
    input  logic [31:0] wdata_i,
    input  logic [4:0]  rs1_i,
    input  logic [4:0]  rs2_i,
    output logic [31:0] rs1_data_o,
    output logic [31:0] rs2_data_o
);

    logic [31:0] regs [REG_COUNT];
    logic        wr_en;

    // x0 and indices past the file are never written
    assign wr_en = we_i && (rd_i != 5'd0) && (int'(rd_i) < REG_COUNT);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // write data bypasses to a same-cycle read
    always_comb begin : read_ports
        rs1_data_o = '0;
        rs2_data_o = '0;
        if (wr_en && (rs1_i == rd_i))
            rs1_data_o = wdata_i;
        else if ((rs1_i != 5'd0) && (int'(rs1_i) < REG_COUNT))
            rs1_data_o = regs[rs1_i];
        if (wr_en && (rs2_i == rd_i))
            rs2_data_o = wdata_i;
        else if ((rs2_i != 5'd0) && (int'(rs2_i) < REG_COUNT))
            rs2_data_o = regs[rs2_i];
    end

endmodule : regfile

`default_nettype wire

/* hw/result_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module result_stage
    import rv32i_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  ex_res_t     ex_res_i,
    input  logic        ex_valid_i,
    output logic        res_full_o,
    output logic        res_accept_o,
    output logic [4:0]  res_rd_o,
    output logic        res_we_o,
    output logic        out_valid_o,
    input  logic        out_ready_i,
    output ex_res_t     out_rec_o,
    output logic        wb_we_o,
    output logic [4:0]  wb_rd_o,
    output logic [31:0] wb_data_o
);

    ex_res_t rec_q;
    logic    valid_q;
    logic    load;

    assign res_accept_o = valid_q && out_ready_i;
    // empty, or draining this cycle
    assign load = !valid_q || out_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= ex_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load)
            rec_q <= ex_res_i;
    end

    assign res_full_o  = valid_q;
    assign res_rd_o    = rec_q.rd;
    assign res_we_o    = rec_q.we;
    assign out_valid_o = valid_q;
    assign out_rec_o   = rec_q;

    // write back only when the record leaves
    assign wb_we_o   = res_accept_o && rec_q.we;
    assign wb_rd_o   = rec_q.rd;
    assign wb_data_o = rec_q.value;

endmodule : result_stage

`default_nettype wire

/* hw/rv32i_core_top.sv */
`timescale 1ns/1ns
`default_nettype none

module rv32i_core_top
    import rv32i_pkg::*;
#(
    parameter int REG_COUNT = 32
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        in_valid_i,
    output logic        in_ready_o,
    input  logic [31:0] in_pc_i,
    input  logic [31:0] in_instr_i,
    output logic        out_valid_o,
    input  logic        out_ready_i,
    output ex_res_t     out_rec_o
);

    id_ex_t      id_ex;
    logic        id_valid;
    logic        ex_stall;
    ex_res_t     ex_res;
    logic        ex_valid;
    logic [4:0]  ex_rd;
    logic        ex_we;
    logic        res_full, res_accept;
    logic [4:0]  res_rd;
    logic        res_we;
    logic        wb_we;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    decode_stage #(.REG_COUNT(REG_COUNT)) u_decode (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_pc_i      (in_pc_i),
        .in_instr_i   (in_instr_i),
        .stall_i      (ex_stall),
        .ex_rd_i      (ex_rd),
        .ex_we_i      (ex_we),
        .ex_valid_i   (ex_valid),
        .res_rd_i     (res_rd),
        .res_we_i     (res_we),
        .res_valid_i  (res_full),
        .res_accept_i (res_accept),
        .wb_we_i      (wb_we),
        .wb_rd_i      (wb_rd),
        .wb_data_i    (wb_data),
        .id_ex_o      (id_ex),
        .id_valid_o   (id_valid)
    );

    execute_stage u_execute (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .id_ex_i      (id_ex),
        .id_valid_i   (id_valid),
        .stall_o      (ex_stall),
        .res_full_i   (res_full),
        .res_accept_i (res_accept),
        .ex_res_o     (ex_res),
        .ex_valid_o   (ex_valid),
        .ex_rd_o      (ex_rd),
        .ex_we_o      (ex_we)
    );

    result_stage u_result (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .ex_res_i     (ex_res),
        .ex_valid_i   (ex_valid),
        .res_full_o   (res_full),
        .res_accept_o (res_accept),
        .res_rd_o     (res_rd),
        .res_we_o     (res_we),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_rec_o    (out_rec_o),
        .wb_we_o      (wb_we),
        .wb_rd_o      (wb_rd),
        .wb_data_o    (wb_data)
    );

endmodule : rv32i_core_top

`default_nettype wire

/* hw/rv32i_pkg.sv */
`default_nettype none

package rv32i_pkg;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_br    = 7'b1100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_csr   = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // encoded as in funct3 of the branch instructions
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_e;

    typedef enum logic {
        alu_a_rs1 = 1'b0,
        alu_a_pc  = 1'b1
    } alumux1_e;

    typedef enum logic {
        alu_b_rs2 = 1'b0,
        alu_b_imm = 1'b1
    } alumux2_e;

    typedef struct packed {
        opcode_e        opcode;
        alu_op_e        alu_op;
        branch_funct3_e cmpop;
        alumux1_e       alumux1_sel;
        alumux2_e       alumux2_sel;
        logic           load_regfile;
        logic           illegal;
    } ctrl_word_t;

    // decode register content
    typedef struct packed {
        logic [31:0] pc;
        ctrl_word_t  ctrl;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic        br_taken;
    } id_ex_t;

    // execute and result register content, also the output record
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] value;
        logic        we;
        logic        br_taken;
        logic        illegal;
    } ex_res_t;

    // bubble: addi that writes nothing
    localparam ctrl_word_t NOP_CTRL = '{
        opcode:       op_imm,
        alu_op:       alu_add,
        cmpop:        beq,
        alumux1_sel:  alu_a_rs1,
        alumux2_sel:  alu_b_imm,
        load_regfile: 1'b0,
        illegal:      1'b0
    };

endpackage : rv32i_pkg

`default_nettype wire

/* test/core_trace.txt */
# columns, all hex: pc instr rd value we br_taken illegal
# register state starts at zero, value of illegal records is not checked
00000000 00500093 01 00000005 1 0 0
00000004 ffd00113 02 fffffffd 1 0 0
00000008 002081b3 03 00000002 1 0 0
0000000c 40208233 04 00000008 1 0 0
00000010 001122b3 05 00000001 1 0 0
00000014 00113333 06 00000000 1 0 0
00000018 401153b3 07 ffffffff 1 0 0
0000001c 00115433 08 07ffffff 1 0 0
00000020 001094b3 09 000000a0 1 0 0
00000024 0020c533 0a fffffff8 1 0 0
00000028 0020e5b3 0b fffffffd 1 0 0
0000002c 0020f633 0c 00000005 1 0 0
00000030 40115693 0d fffffffe 1 0 0
00000034 12345737 0e 12345000 1 0 0
00000038 00001797 0f 00001038 1 0 0
0000003c 00708013 00 0000000c 0 0 0
00000040 00118813 10 00000003 1 0 0
00000044 010808b3 11 00000006 1 0 0
00000048 00108463 08 00000050 0 1 0
0000004c fe209ee3 1d 00000048 0 1 0
00000050 00114863 10 00000060 0 1 0
00000054 00115863 10 00000064 0 0 0
00000058 0220e063 00 00000078 0 1 0
0000005c 0220f063 00 0000007c 0 0 0
00000060 0000a903 12 00000000 0 0 1
00000064 0020a223 04 00000000 0 0 1
00000068 010000ef 01 00000000 0 0 1
0000006c 021089b3 13 00000000 0 0 1
00000070 00108a13 14 00000006 1 0 0
00000074 011a0ab3 15 0000000c 1 0 0
00000078 01ef8b33 16 00000000 1 0 0

/* test/tb_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_checker
    import rv32i_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    in_valid_i,
    input  logic    in_ready_i,
    input  logic    out_valid_i,
    input  logic    out_ready_i,
    input  ex_res_t out_rec_i,
    output int      acc_cnt_o,
    output int      rec_cnt_o,
    output int      mism_cnt_o,
    output int      extra_cnt_o
);

    int acc_cnt   = 0;
    int rec_cnt   = 0;
    int mism_cnt  = 0;
    int extra_cnt = 0;

    task automatic report_field(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: record %0d (pc %h) %s is %h, expected %h",
                     $time, rec_cnt, out_rec_i.pc, name, got, exp);
            mism_cnt++;
        end
    endtask

    task automatic compare_record(input ex_res_t exp);
        report_field("pc", out_rec_i.pc, exp.pc);
        report_field("rd", 32'(out_rec_i.rd), 32'(exp.rd));
        // illegal records carry no defined value
        if (!exp.illegal)
            report_field("value", out_rec_i.value, exp.value);
        report_field("we", 32'(out_rec_i.we), 32'(exp.we));
        report_field("br_taken", 32'(out_rec_i.br_taken), 32'(exp.br_taken));
        report_field("illegal", 32'(out_rec_i.illegal), 32'(exp.illegal));
    endtask

    always @(posedge clk) begin
        if (rst_n_i) begin
            if (in_valid_i && in_ready_i)
                acc_cnt++;
            if (out_valid_i && out_ready_i) begin
                if (rec_cnt < tb_top.exp_q.size()) begin
                    compare_record(tb_top.exp_q[rec_cnt]);
                end else begin
                    $display("%0t ns: extra record for pc %h beyond the end of the trace",
                             $time, out_rec_i.pc);
                    extra_cnt++;
                end
                rec_cnt++;
            end
        end
    end

    assign acc_cnt_o   = acc_cnt;
    assign rec_cnt_o   = rec_cnt;
    assign mism_cnt_o  = mism_cnt;
    assign extra_cnt_o = extra_cnt;

endmodule : tb_checker

`default_nettype wire

/* test/tb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_top
    import rv32i_pkg::*;
();

    localparam int    TIMEOUT    = 200;
    localparam string TRACE_FILE = "test/core_trace.txt";

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic        in_valid_i;
    logic        in_ready_o;
    logic [31:0] in_pc_i;
    logic [31:0] in_instr_i;
    logic        out_valid_o;
    logic        out_ready_i;
    ex_res_t     out_rec_o;

    // expected records, also read by the checker
    ex_res_t     exp_q[$];
    logic [31:0] instr_q[$];

    int          seed = 32'h91a5c765;
    logic        hold_off;
    int          acc_cnt;
    int          rec_cnt;
    int          mism_cnt;
    int          extra_cnt;
    int          other_errs = 0;

    rv32i_core_top #(.REG_COUNT(32)) UUT (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_pc_i     (in_pc_i),
        .in_instr_i  (in_instr_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_rec_o   (out_rec_o)
    );

    tb_checker chk (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_i  (in_ready_o),
        .out_valid_i (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_rec_i   (out_rec_o),
        .acc_cnt_o   (acc_cnt),
        .rec_cnt_o   (rec_cnt),
        .mism_cnt_o  (mism_cnt),
        .extra_cnt_o (extra_cnt)
    );

    always #2 clk = ~clk;

    // one random draw per cycle for both the output stalls and the input gaps
    always @(posedge clk) begin : random_gaps
        logic [31:0] rnd;
        rnd = $random(seed);
        out_ready_i <= (rnd[1:0] != 2'b00);
        hold_off    <= (rnd[4:2] == 3'b000);
    end

    task automatic load_trace();
        int          fd;
        int          n;
        string       line;
        logic [31:0] pc, instr, rd, value, we, br, ill;
        ex_res_t     rec;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("could not open the trace file %s", TRACE_FILE);
            other_errs++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // comment and empty lines do not scan as seven fields
            n = $sscanf(line, "%h %h %h %h %h %h %h", pc, instr, rd, value, we, br, ill);
            if (n == 7) begin
                rec.pc       = pc;
                rec.rd       = rd[4:0];
                rec.value    = value;
                rec.we       = we[0];
                rec.br_taken = br[0];
                rec.illegal  = ill[0];
                exp_q.push_back(rec);
                instr_q.push_back(instr);
            end
        end
        $fclose(fd);
    endtask

    task automatic send_instr(input int idx, output logic sent);
        int waited;
        waited = 0;
        // idle cycles while the random hold is on
        while (hold_off && waited < TIMEOUT) begin
            in_valid_i <= 1'b0;
            @(posedge clk);
            waited++;
        end
        in_valid_i <= 1'b1;
        in_pc_i    <= exp_q[idx].pc;
        in_instr_i <= instr_q[idx];
        sent   = 1'b0;
        waited = 0;
        // ready is looked at mid cycle, the transfer is at the next rising edge
        while (!sent && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (in_ready_o)
                sent = 1'b1;
            @(posedge clk);
        end
    endtask

    initial begin : main
        logic sent;
        int   waited;
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        in_pc_i     = '0;
        in_instr_i  = '0;
        out_ready_i = 1'b0;
        hold_off    = 1'b0;
        load_trace();
        if (exp_q.size() == 0) begin
            $display("the trace file holds no instructions");
            other_errs++;
        end
        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;

        sent = 1'b1;
        for (int i = 0; i < exp_q.size() && sent; i++) begin
            send_instr(i, sent);
            if (!sent) begin
                $display("timeout: instruction at pc %h was never accepted", exp_q[i].pc);
                other_errs++;
            end
        end
        in_valid_i <= 1'b0;

        waited = 0;
        while (rec_cnt < exp_q.size() && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (rec_cnt < exp_q.size()) begin
            $display("timeout: %0d records never arrived", exp_q.size() - rec_cnt);
            other_errs++;
        end
        // room for any record beyond the end of the trace
        repeat (8) @(posedge clk);
        @(negedge clk);
        if (acc_cnt != exp_q.size()) begin
            $display("%0d instructions accepted, trace has %0d", acc_cnt, exp_q.size());
            other_errs++;
        end

        $display("errors: %0d mismatches, %0d extra records, %0d other (%0d of %0d records)",
                 mism_cnt, extra_cnt, other_errs, rec_cnt, exp_q.size());
        if (mism_cnt == 0 && extra_cnt == 0 && other_errs == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule : tb_top

`default_nettype wire
